/* gb_mcycle_core.f */
+incdir+hdl
+incdir+tb
hdl/gb_pkg.sv
hdl/bus_sequencer.sv
hdl/interrupt_unit.sv
hdl/pc_sp_unit.sv
hdl/gb_mcycle_core.sv
tb/tb_gb_mcycle_core.sv

/* hdl/bus_sequencer.sv */
`timescale 1ns/1ps
`include "gb_defs.svh"

module bus_sequencer import gb_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  uop_t                  uop,
    input  ptr_t                  ptrs,
    input  logic [`GB_DATA_W-1:0] din,
    output tphase_t               tphase,
    output logic [`GB_ADDR_W-1:0] temp,
    output logic [`GB_ADDR_W-1:0] a,
    output logic [`GB_DATA_W-1:0] dout,
    output logic                  rd,
    output logic                  wr,
    output logic                  phi
);

    localparam int CT_W = $clog2(`GB_TCYCLES);

    logic [CT_W-1:0]       ct_state;
    logic [`GB_ADDR_W-1:0] ab_sel;    // Address for this M-cycle
    logic [`GB_DATA_W-1:0] db_sel;    // Write data for this M-cycle
    logic                  bus_reads;

    ////////////////////
    // T-cycle counter
    ////////////////////

    // Free running and wrapping every M-cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ct_state <= '0;
        end else begin
            ct_state <= ct_state + 1'b1;
        end
    end

    assign tphase.t0         = (ct_state == CT_W'(0));
    assign tphase.t1         = (ct_state == CT_W'(1));
    assign tphase.t2         = (ct_state == CT_W'(2));
    assign tphase.t3         = (ct_state == CT_W'(3));
    assign tphase.fetch_done = tphase.t2 && (uop.bus_op == BUS_FETCH);

    ////////////////////
    // Bus source select
    ////////////////////

    always_comb begin
        case (uop.ab_src)
            AB_PC: ab_sel = ptrs.pc;
            AB_TEMP: begin
                if (uop.high_mask) begin
                    ab_sel = {`GB_HIGH_PAGE, temp[`GB_DATA_W-1:0]};
                end else begin
                    ab_sel = temp;
                end
            end
            AB_SP:   ab_sel = ptrs.sp;
            default: ab_sel = ptrs.pc; // Unused code
        endcase
    end

    always_comb begin
        case (uop.db_src)
            DB_PC_LO:   db_sel = ptrs.pc[`GB_DATA_W-1:0];
            DB_PC_HI:   db_sel = ptrs.pc[`GB_ADDR_W-1:`GB_DATA_W];
            DB_TEMP_LO: db_sel = temp[`GB_DATA_W-1:0];
            default:    db_sel = temp[`GB_ADDR_W-1:`GB_DATA_W];
        endcase
    end

    assign bus_reads = (uop.bus_op == BUS_FETCH) || (uop.bus_op == BUS_READ);

    ////////////////////
    // Bus registers
    ////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            a    <= '0;
            dout <= '0;
            rd   <= 1'b0;
            wr   <= 1'b0;
            phi  <= 1'b1;
            temp <= '0;
        end else begin
            if (tphase.t0) begin
                // Address setup
                a   <= ab_sel;
                rd  <= bus_reads;
                wr  <= 1'b0;
                phi <= 1'b1;
            end else if (tphase.t2) begin
                rd  <= 1'b0;
                phi <= 1'b0;
                if (uop.bus_op == BUS_WRITE) begin
                    wr   <= 1'b1;
                    dout <= db_sel;
                end else begin
                    wr <= 1'b0;
                end
                // Data latch into the immediate register
                if (uop.bus_op == BUS_READ) begin
                    if (uop.imm_hi) begin
                        temp[`GB_ADDR_W-1:`GB_DATA_W] <= din;
                    end else begin
                        temp[`GB_DATA_W-1:0] <= din;
                    end
                end
            end else if (tphase.t3) begin
                rd   <= 1'b0; // Bus idle
                wr   <= 1'b0;
                dout <= '0;
            end
        end
    end

endmodule

/* hdl/gb_defs.svh */
`ifndef GB_DEFS_SVH
`define GB_DEFS_SVH

// Bus and register widths
`define GB_ADDR_W 16
`define GB_DATA_W 8

// T-cycles in one M-cycle
`define GB_TCYCLES 4

// Interrupt sources
`define GB_NUM_INT 5

// RST-style vector table of base plus step times source index
`define GB_INT_VEC_BASE 16'h0040
`define GB_INT_VEC_STEP 16'd8

// Upper address byte for LDH style accesses
`define GB_HIGH_PAGE 8'hFF

`endif

/* hdl/gb_mcycle_core.sv */
`timescale 1ns/1ps
`include "gb_defs.svh"

module gb_mcycle_core import gb_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  uop_t                   uop,
    input  logic [`GB_DATA_W-1:0]  din,
    input  logic [`GB_NUM_INT-1:0] int_en,
    input  logic [`GB_NUM_INT-1:0] int_flags_in,
    input  logic [`GB_DATA_W-1:0]  key_in,
    output logic [`GB_ADDR_W-1:0]  a,
    output logic [`GB_DATA_W-1:0]  dout,
    output logic                   rd,
    output logic                   wr,
    output logic                   phi,
    output logic [`GB_NUM_INT-1:0] int_flags_out,
    output logic                   wake
);

    tphase_t               tphase;
    logic [`GB_ADDR_W-1:0] temp;    // 16-bit immediate
    ptr_t                  ptrs;
    logic                  dispatch_ack;
    int_req_t              int_req;

    // Phase counter and external bus
    bus_sequencer u_bus_sequencer (
        .clk    (clk),
        .rst    (rst),
        .uop    (uop),
        .ptrs   (ptrs),
        .din    (din),
        .tphase (tphase),
        .temp   (temp),
        .a      (a),
        .dout   (dout),
        .rd     (rd),
        .wr     (wr),
        .phi    (phi)
    );

    interrupt_unit u_interrupt_unit (
        .clk           (clk),
        .rst           (rst),
        .uop           (uop),
        .pc            (ptrs.pc),
        .tphase        (tphase),
        .dispatch_ack  (dispatch_ack),
        .int_en        (int_en),
        .int_flags_in  (int_flags_in),
        .key_in        (key_in),
        .int_req       (int_req),
        .int_flags_out (int_flags_out),
        .wake          (wake)
    );

    pc_sp_unit u_pc_sp_unit (
        .clk          (clk),
        .rst          (rst),
        .uop          (uop),
        .tphase       (tphase),
        .temp         (temp),
        .int_req      (int_req),
        .ptrs         (ptrs),
        .dispatch_ack (dispatch_ack)
    );

endmodule

/* hdl/gb_pkg.sv */
`include "gb_defs.svh"

package gb_pkg;

    // Bus action of one M-cycle
    typedef enum logic [1:0] {
        BUS_IDLE  = 2'b00,
        BUS_FETCH = 2'b01,
        BUS_WRITE = 2'b10,
        BUS_READ  = 2'b11
    } bus_op_t;

    typedef enum logic [1:0] {
        AB_PC   = 2'b00,
        AB_TEMP = 2'b01,
        AB_SP   = 2'b10
    } ab_src_t;

    typedef enum logic [1:0] {
        DB_PC_LO   = 2'b00,
        DB_PC_HI   = 2'b01,
        DB_TEMP_LO = 2'b10,
        DB_TEMP_HI = 2'b11
    } db_src_t;

    // Pointer step done over T1 and T2
    typedef enum logic [1:0] {
        CT_NONE   = 2'b00,
        CT_PC_INC = 2'b01,
        CT_SP_DEC = 2'b10,
        CT_SP_INC = 2'b11
    } ct_op_t;

    typedef struct packed {
        bus_op_t bus_op;
        ab_src_t ab_src;
        db_src_t db_src;
        ct_op_t  ct_op;
        logic    high_mask; // Force high page on temp address
        logic    imm_hi;    // Read fills temp upper byte
        logic    pc_load;
        logic    ime;
        logic    halt;
        logic    stop;
    } uop_t;

    typedef struct packed {
        logic t0;
        logic t1;
        logic t2;
        logic t3;
        logic fetch_done; // T2 of a fetch cycle
    } tphase_t;

    typedef struct packed {
        logic [`GB_ADDR_W-1:0] pc;
        logic [`GB_ADDR_W-1:0] sp;
    } ptr_t;

    typedef struct packed {
        logic                  dispatch;
        logic [`GB_ADDR_W-1:0] vec;
    } int_req_t;

endpackage

/* hdl/interrupt_unit.sv */
`timescale 1ns/1ps
`include "gb_defs.svh"

module interrupt_unit import gb_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  uop_t                   uop,
    input  logic [`GB_ADDR_W-1:0]  pc,
    input  tphase_t                tphase,
    input  logic                   dispatch_ack,
    input  logic [`GB_NUM_INT-1:0] int_en,
    input  logic [`GB_NUM_INT-1:0] int_flags_in,
    input  logic [`GB_DATA_W-1:0]  key_in,
    output int_req_t               int_req,
    output logic [`GB_NUM_INT-1:0] int_flags_out,
    output logic                   wake
);

    localparam int IDX_W = $clog2(`GB_NUM_INT);

    logic [`GB_NUM_INT-1:0] masked;
    logic [`GB_NUM_INT-1:0] lowest;     // One-hot of the serviced source
    logic [IDX_W-1:0]       idx;
    logic                   any_masked;
    logic                   any_enabled; // IME plays no part here
    logic                   wake_next;
    logic                   dispatch;

    assign masked      = int_flags_in & int_en & {`GB_NUM_INT{uop.ime}};
    assign any_masked  = |masked;
    assign any_enabled = |(int_flags_in & int_en);

    // Lowest index wins
    always_comb begin
        idx = '0;
        for (int i = `GB_NUM_INT - 1; i >= 0; i--) begin
            if (masked[i]) begin
                idx = IDX_W'(i);
            end
        end
    end

    assign lowest = any_masked ? (`GB_NUM_INT'(1) << idx) : '0;

    assign int_req.dispatch = dispatch;
    assign int_req.vec      = any_masked ?
                              (`GB_INT_VEC_BASE + `GB_INT_VEC_STEP * `GB_ADDR_W'(idx)) : pc;

    assign int_flags_out = dispatch_ack ? (int_flags_in & ~lowest) : int_flags_in;

    ////////////////////
    // Dispatch and wake
    ////////////////////

    // Dispatch only starts at an instruction fetch
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dispatch <= 1'b0;
        end else if (dispatch_ack) begin
            dispatch <= 1'b0;
        end else if (tphase.fetch_done && !dispatch && any_masked) begin
            dispatch <= 1'b1;
        end
    end

    always_comb begin
        if (uop.halt) begin
            wake_next = any_enabled;
        end else if (uop.stop) begin
            wake_next = any_enabled || (|key_in); // Keypad also wakes from stop
        end else begin
            wake_next = 1'b0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wake <= 1'b0;
        end else begin
            wake <= wake_next;
        end
    end

endmodule

/* hdl/pc_sp_unit.sv */
`timescale 1ns/1ps
`include "gb_defs.svh"

module pc_sp_unit import gb_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  uop_t                  uop,
    input  tphase_t               tphase,
    input  logic [`GB_ADDR_W-1:0] temp,
    input  int_req_t              int_req,
    output ptr_t                  ptrs,
    output logic                  dispatch_ack
);

    logic [`GB_ADDR_W-1:0] pc;
    logic [`GB_ADDR_W-1:0] sp;
    logic                  step_en;
    logic                  step_pc;  // PC is the target, else SP
    logic                  step_sub;
    logic [`GB_ADDR_W-1:0] step_src;
    logic [`GB_DATA_W-1:0] add_a;
    logic [`GB_DATA_W-1:0] add_b;
    logic [`GB_DATA_W:0]   add_sum;  // MSB is carry or borrow
    logic                  carry;
    logic                  we_lo;
    logic                  we_hi;

    assign ptrs.pc = pc;
    assign ptrs.sp = sp;

    // Jump with a pending dispatch acknowledges it
    assign dispatch_ack = tphase.t0 && uop.pc_load && int_req.dispatch;

    ////////////////////
    // Byte serial step
    ////////////////////

    assign step_en  = (uop.ct_op != CT_NONE);
    assign step_pc  = (uop.ct_op == CT_PC_INC);
    assign step_sub = (uop.ct_op == CT_SP_DEC);
    assign step_src = step_pc ? pc : sp;

    // T1 works on the low byte, T2 on the high byte
    assign add_a = tphase.t1 ? step_src[`GB_DATA_W-1:0] : step_src[`GB_ADDR_W-1:`GB_DATA_W];
    assign add_b = tphase.t1 ? `GB_DATA_W'(1) : `GB_DATA_W'(carry);

    always_comb begin
        if (step_sub) begin
            add_sum = {1'b0, add_a} - {1'b0, add_b};
        end else begin
            add_sum = {1'b0, add_a} + {1'b0, add_b};
        end
    end

    assign we_lo = step_en && tphase.t1;
    assign we_hi = step_en && tphase.t2;

    ////////////////////
    // Pointer registers
    ////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc    <= '0;
            sp    <= '0;
            carry <= 1'b0;
        end else begin
            if (tphase.t0 && uop.pc_load) begin
                pc <= int_req.dispatch ? int_req.vec : temp;
            end

            if (we_lo) begin
                carry <= add_sum[`GB_DATA_W]; // Held for the high byte
                if (step_pc) begin
                    pc[`GB_DATA_W-1:0] <= add_sum[`GB_DATA_W-1:0];
                end else begin
                    sp[`GB_DATA_W-1:0] <= add_sum[`GB_DATA_W-1:0];
                end
            end

            if (we_hi) begin
                if (step_pc) begin
                    pc[`GB_ADDR_W-1:`GB_DATA_W] <= add_sum[`GB_DATA_W-1:0];
                end else begin
                    sp[`GB_ADDR_W-1:`GB_DATA_W] <= add_sum[`GB_DATA_W-1:0];
                end
            end
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, then scan the log for a failure
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_gb_mcycle_core \
    -f gb_mcycle_core.f -o tb_sim > build.log 2>&1 || { cat build.log; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1 || { cat sim.log; echo "simulation did not complete"; exit 1; }
cat sim.log

grep -q "STATUS: FAIL" sim.log && exit 1 || exit 0

/* tb/gb_core_model.svh */
`ifndef GB_CORE_MODEL_SVH
`define GB_CORE_MODEL_SVH

// Predicted core state advanced once per clock edge
logic [1:0]            exp_ct;
logic [`GB_ADDR_W-1:0] exp_a;
logic [`GB_ADDR_W-1:0] exp_pc;
logic [`GB_ADDR_W-1:0] exp_sp;
logic [`GB_ADDR_W-1:0] exp_temp;
logic [`GB_DATA_W-1:0] exp_dout;
logic                  exp_rd;
logic                  exp_wr;
logic                  exp_phi;
logic                  exp_carry;    // Low byte overflow or borrow
logic                  exp_dispatch;
logic                  exp_wake;

// Lowest pending source allowed by enables and IME or -1 if none
function automatic int pick_source(uop_t u, logic [`GB_NUM_INT-1:0] en,
                                   logic [`GB_NUM_INT-1:0] flags);
    logic [`GB_NUM_INT-1:0] pend;
    pend = flags & en & {`GB_NUM_INT{u.ime}};
    for (int i = 0; i < `GB_NUM_INT; i++) begin
        if (pend[i]) begin
            return i;
        end
    end
    return -1;
endfunction

function automatic logic acknowledging(uop_t u);
    return (exp_ct == 2'd0) && u.pc_load && exp_dispatch;
endfunction

function automatic logic [`GB_NUM_INT-1:0] expected_flags(uop_t u,
        logic [`GB_NUM_INT-1:0] en, logic [`GB_NUM_INT-1:0] flags);
    int src;
    src = pick_source(u, en, flags);
    if (acknowledging(u) && src >= 0) begin
        return flags & ~(`GB_NUM_INT'(1) << src); // Serviced source cleared
    end
    return flags;
endfunction

task automatic reset_model();
    exp_ct       = 2'd0;
    exp_a        = '0;
    exp_pc       = '0;
    exp_sp       = '0;
    exp_temp     = '0;
    exp_dout     = '0;
    exp_rd       = 1'b0;
    exp_wr       = 1'b0;
    exp_phi      = 1'b1;
    exp_carry    = 1'b0;
    exp_dispatch = 1'b0;
    exp_wake     = 1'b0;
endtask

task automatic step_model(input logic r, input uop_t u, input logic [7:0] d,
        input logic [`GB_NUM_INT-1:0] en, input logic [`GB_NUM_INT-1:0] flags,
        input logic [7:0] keys);
    int                    src;
    logic [`GB_ADDR_W-1:0] ptr;   // Pointer being stepped
    logic [`GB_DATA_W-1:0] wdata;
    logic                  any_en;
    logic                  dec;
    src    = pick_source(u, en, flags);
    ptr    = (u.ct_op == CT_PC_INC) ? exp_pc : exp_sp;
    dec    = (u.ct_op == CT_SP_DEC);
    any_en = |(flags & en);
    case (u.db_src)
        DB_PC_LO:   wdata = exp_pc[7:0];
        DB_PC_HI:   wdata = exp_pc[15:8];
        DB_TEMP_LO: wdata = exp_temp[7:0];
        default:    wdata = exp_temp[15:8];
    endcase
    if (r) begin
        reset_model();
    end else begin
        exp_wake = u.halt ? any_en : (u.stop && (any_en || (|keys)));
        case (exp_ct)
            2'd0: begin
                case (u.ab_src)
                    AB_PC:   exp_a = exp_pc;
                    AB_SP:   exp_a = exp_sp;
                    default: exp_a = u.high_mask ? {8'hFF, exp_temp[7:0]} : exp_temp;
                endcase
                exp_rd  = (u.bus_op == BUS_FETCH) || (u.bus_op == BUS_READ);
                exp_wr  = 1'b0;
                exp_phi = 1'b1;
                if (u.pc_load && exp_dispatch) begin
                    // Vector of the lowest source or stay put with nothing pending
                    exp_pc       = (src >= 0) ? 16'h0040 + 16'(src * 8) : exp_pc;
                    exp_dispatch = 1'b0;
                end else if (u.pc_load) begin
                    exp_pc = exp_temp;
                end
            end
            2'd1: begin
                exp_carry = dec ? (ptr[7:0] == 8'h00) : (ptr[7:0] == 8'hFF);
                ptr[7:0]  = dec ? ptr[7:0] - 8'd1 : ptr[7:0] + 8'd1;
            end
            2'd2: begin
                exp_rd    = 1'b0;
                exp_phi   = 1'b0;
                exp_wr    = (u.bus_op == BUS_WRITE);
                exp_dout  = exp_wr ? wdata : exp_dout;
                ptr[15:8] = dec ? ptr[15:8] - 8'(exp_carry) : ptr[15:8] + 8'(exp_carry);
                if (u.bus_op == BUS_READ && u.imm_hi) begin
                    exp_temp[15:8] = d;
                end else if (u.bus_op == BUS_READ) begin
                    exp_temp[7:0] = d;
                end
                if (u.bus_op == BUS_FETCH && src >= 0) begin
                    exp_dispatch = 1'b1;
                end
            end
            default: begin
                exp_rd   = 1'b0;
                exp_wr   = 1'b0;
                exp_dout = '0;
            end
        endcase
        if ((exp_ct == 2'd1 || exp_ct == 2'd2) && u.ct_op == CT_PC_INC) begin
            exp_pc = ptr;
        end else if ((exp_ct == 2'd1 || exp_ct == 2'd2) && u.ct_op != CT_NONE) begin
            exp_sp = ptr;
        end
        exp_ct = exp_ct + 2'd1;
    end
endtask

`endif

/* tb/tb_gb_mcycle_core.sv */
`timescale 1ns/1ps
`include "gb_defs.svh"

module tb_gb_mcycle_core import gb_pkg::*; ();

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_MCYCLES  = 400;
    localparam int SEED         = 98629;
    localparam int RUN_CYCLES   = RESET_CYCLES + NUM_MCYCLES * `GB_TCYCLES;
    localparam int TIMEOUT_NS   = (RUN_CYCLES + 40) * CLK_PERIOD;

    logic                   clk;
    logic                   rst;
    uop_t                   uop;
    logic [`GB_DATA_W-1:0]  din;
    logic [`GB_NUM_INT-1:0] int_en;
    logic [`GB_NUM_INT-1:0] int_flags_in;
    logic [`GB_DATA_W-1:0]  key_in;
    logic [`GB_ADDR_W-1:0]  a;
    logic [`GB_DATA_W-1:0]  dout;
    logic                   rd;
    logic                   wr;
    logic                   phi;
    logic [`GB_NUM_INT-1:0] int_flags_out;
    logic                   wake;
    logic [`GB_NUM_INT-1:0] flag_reg;   // Software view of the IF register
    int                     checks;
    int                     errors;
    int                     dispatches;
    int                     wakes;

    `include "gb_core_model.svh"

    gb_mcycle_core i_dut (
        .clk           (clk),
        .rst           (rst),
        .uop           (uop),
        .din           (din),
        .int_en        (int_en),
        .int_flags_in  (int_flags_in),
        .key_in        (key_in),
        .a             (a),
        .dout          (dout),
        .rd            (rd),
        .wr            (wr),
        .phi           (phi),
        .int_flags_out (int_flags_out),
        .wake          (wake)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////
    // Checks
    ////////////////////

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_outputs();
        check_value("a", 32'(a), 32'(exp_a));
        check_value("dout", 32'(dout), 32'(exp_dout));
        check_value("rd", 32'(rd), 32'(exp_rd));
        check_value("wr", 32'(wr), 32'(exp_wr));
        check_value("phi", 32'(phi), 32'(exp_phi));
        check_value("int_flags_out", 32'(int_flags_out),
                    32'(expected_flags(uop, int_en, int_flags_in)));
        check_value("wake", 32'(wake), 32'(exp_wake));
        dispatches += int'(acknowledging(uop) && pick_source(uop, int_en, int_flags_in) >= 0);
        wakes      += int'(exp_wake);
    endtask

    // New control word and side inputs at the start of an M-cycle
    task automatic draw_mcycle();
        uop.bus_op    = bus_op_t'(2'($urandom_range(3, 0)));
        uop.ab_src    = ab_src_t'(2'($urandom_range(2, 0)));
        uop.db_src    = db_src_t'(2'($urandom_range(3, 0)));
        uop.ct_op     = ct_op_t'(2'($urandom_range(3, 0)));
        uop.high_mask = 1'($urandom_range(1, 0));
        uop.imm_hi    = 1'($urandom_range(1, 0));
        uop.pc_load   = ($urandom_range(3, 0) == 0);
        uop.ime       = 1'($urandom_range(1, 0));
        uop.halt      = ($urandom_range(5, 0) == 0);
        uop.stop      = ($urandom_range(5, 0) == 0);
        din           = 8'($urandom);
        int_en        = `GB_NUM_INT'($urandom);
        key_in        = ($urandom_range(3, 0) == 0) ? 8'($urandom) : 8'h00;
        // Sparse new requests and now and then a full clear
        flag_reg      = flag_reg | (`GB_NUM_INT'($urandom) & `GB_NUM_INT'($urandom));
        if ($urandom_range(15, 0) == 0) begin
            flag_reg = '0;
        end
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        void'($urandom(SEED));
        rst          = 1'b1;
        uop          = '0;
        din          = '0;
        int_en       = '0;
        int_flags_in = '0;
        key_in       = '0;
        flag_reg     = '0;
        checks       = 0;
        errors       = 0;
        dispatches   = 0;
        wakes        = 0;
        reset_model();
        for (int cyc = 0; cyc < RUN_CYCLES; cyc++) begin
            @(posedge clk);
            step_model(rst, uop, din, int_en, int_flags_in, key_in);
            #1;
            if (cyc == RESET_CYCLES - 1) begin
                rst = 1'b0;
            end
            if (!rst && exp_ct == 2'd0) begin
                draw_mcycle();
            end
            int_flags_in = flag_reg;
            @(negedge clk);
            check_outputs();
            flag_reg = int_flags_out; // Acknowledged bit stays cleared
        end
        if (dispatches == 0) begin
            errors++;
            $display("no interrupt vector was loaded during the run");
        end
        if (wakes == 0) begin
            errors++;
            $display("wake was never expected high during the run");
        end
        $display("checks %0d, errors %0d, dispatches %0d, wake cycles %0d",
                 checks, errors, dispatches, wakes);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("timeout: run still going after %0d ns", TIMEOUT_NS);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule
